//--- source/soc_bus_consts.svh
/*
 * SoC memory bus constants: bus widths, address map and SRAM size
 */
`ifndef SOC_BUS_CONSTS_SVH
`define SOC_BUS_CONSTS_SVH

`define ADDR_LEN 32
`define DATA_LEN 32
`define ID_LEN 4
`define STRB_LEN (`DATA_LEN / 8)	// one strobe bit per byte
`define AXLEN_LEN 8
`define RESP_LEN 2

`define CLINT_BASE 32'h0200_0000
`define CLINT_MASK 32'hFFFF_0000	// 64 KiB region
`define MTIME_LO_ADDR 16'hBFF8
`define MTIME_HI_ADDR 16'hBFFC

`define SRAM_DEPTH_WORDS 256
`define SRAM_IDX_LEN 8	// word index taken from addr[9:2]

`define RESP_OKAY 2'b00

`endif

//--- source/soc_bus_pkg.sv
/*
 * SoC memory bus types: device select, burst kind and SRAM FSM states
 */
`default_nettype none

package soc_bus_pkg;

	typedef enum logic {
		DEV_SRAM  = 1'b0,
		DEV_CLINT = 1'b1
	} device_e;

	// AXI burst encoding, WRAP not supported
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01
	} burst_e;

	typedef enum logic [1:0] {
		SRAM_IDLE,
		SRAM_READ,
		SRAM_WRITE,
		SRAM_RESP
	} sram_state_e;

endpackage

`default_nettype wire

//--- source/device_select.sv
/*
 * Read address decoder, picks SRAM or CLINT and holds the route
 * until the last read beat has been accepted
 */
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_consts.svh"

module device_select (
	input  logic                   clock,
	input  logic                   rst_n_i,
	input  logic [`ADDR_LEN-1:0]   ar_addr_i,
	input  logic                   ar_valid_i,
	input  logic                   ar_ready_i,
	input  logic                   r_valid_i,
	input  logic                   r_ready_i,
	input  logic                   r_last_i,
	output soc_bus_pkg::device_e   rd_sel_o
);

	soc_bus_pkg::device_e addr_dev;	// decode of the current ar address
	soc_bus_pkg::device_e held_dev;
	logic                 busy;

	assign addr_dev = ((ar_addr_i & `CLINT_MASK) == `CLINT_BASE) ?
		soc_bus_pkg::DEV_CLINT : soc_bus_pkg::DEV_SRAM;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy     <= 1'b0;
			held_dev <= soc_bus_pkg::DEV_SRAM;
		end else if (!busy) begin
			if (ar_valid_i && ar_ready_i) begin
				busy     <= 1'b1;	// request taken, lock route
				held_dev <= addr_dev;
			end
		end else if (r_valid_i && r_ready_i && r_last_i) begin
			busy <= 1'b0;
		end
	end

	// responses go back to whichever slave took the request
	assign rd_sel_o = busy ? held_dev : addr_dev;

endmodule

`default_nettype wire

//--- source/bus_xbar.sv
/*
 * Bus crossbar, steers the read channels to SRAM or CLINT
 * and forwards every write to the SRAM
 */
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_consts.svh"

module bus_xbar (
	input  logic [`ADDR_LEN-1:0]  ar_addr_i,
	input  logic                  ar_valid_i,
	output logic                  ar_ready_o,
	input  logic [`ID_LEN-1:0]    ar_id_i,
	input  logic [`AXLEN_LEN-1:0] ar_len_i,
	input  logic [1:0]            ar_burst_i,
	output logic [`DATA_LEN-1:0]  r_data_o,
	output logic [`RESP_LEN-1:0]  r_resp_o,
	output logic                  r_valid_o,
	input  logic                  r_ready_i,
	output logic                  r_last_o,
	output logic [`ID_LEN-1:0]    r_id_o,
	input  logic [`ADDR_LEN-1:0]  aw_addr_i,
	input  logic                  aw_valid_i,
	output logic                  aw_ready_o,
	input  logic [`ID_LEN-1:0]    aw_id_i,
	input  logic [1:0]            aw_burst_i,
	input  logic [`DATA_LEN-1:0]  w_data_i,
	input  logic [`STRB_LEN-1:0]  w_strb_i,
	input  logic                  w_valid_i,
	output logic                  w_ready_o,
	input  logic                  w_last_i,
	output logic [`RESP_LEN-1:0]  b_resp_o,
	output logic                  b_valid_o,
	input  logic                  b_ready_i,
	output logic [`ID_LEN-1:0]    b_id_o,

	input  soc_bus_pkg::device_e  rd_sel_i,

	output logic [`ADDR_LEN-1:0]  sram_ar_addr_o,
	output logic                  sram_ar_valid_o,
	input  logic                  sram_ar_ready_i,
	output logic [`ID_LEN-1:0]    sram_ar_id_o,
	output logic [`AXLEN_LEN-1:0] sram_ar_len_o,
	output logic [1:0]            sram_ar_burst_o,
	input  logic [`DATA_LEN-1:0]  sram_r_data_i,
	input  logic [`RESP_LEN-1:0]  sram_r_resp_i,
	input  logic                  sram_r_valid_i,
	output logic                  sram_r_ready_o,
	input  logic                  sram_r_last_i,
	input  logic [`ID_LEN-1:0]    sram_r_id_i,
	output logic [`ADDR_LEN-1:0]  sram_aw_addr_o,
	output logic                  sram_aw_valid_o,
	input  logic                  sram_aw_ready_i,
	output logic [`ID_LEN-1:0]    sram_aw_id_o,
	output logic [1:0]            sram_aw_burst_o,
	output logic [`DATA_LEN-1:0]  sram_w_data_o,
	output logic [`STRB_LEN-1:0]  sram_w_strb_o,
	output logic                  sram_w_valid_o,
	input  logic                  sram_w_ready_i,
	output logic                  sram_w_last_o,
	input  logic [`RESP_LEN-1:0]  sram_b_resp_i,
	input  logic                  sram_b_valid_i,
	output logic                  sram_b_ready_o,
	input  logic [`ID_LEN-1:0]    sram_b_id_i,

	output logic [`ADDR_LEN-1:0]  clint_ar_addr_o,
	output logic                  clint_ar_valid_o,
	input  logic                  clint_ar_ready_i,
	input  logic [`DATA_LEN-1:0]  clint_r_data_i,
	input  logic [`RESP_LEN-1:0]  clint_r_resp_i,
	input  logic                  clint_r_valid_i,
	input  logic                  clint_r_last_i,
	output logic                  clint_r_ready_o
);

	logic to_clint;

	assign to_clint = (rd_sel_i == soc_bus_pkg::DEV_CLINT);

	// request side, unselected slave sees no valid
	assign sram_ar_addr_o   = ar_addr_i;
	assign sram_ar_valid_o  = ar_valid_i & ~to_clint;
	assign sram_ar_id_o     = ar_id_i;
	assign sram_ar_len_o    = ar_len_i;
	assign sram_ar_burst_o  = ar_burst_i;
	assign sram_r_ready_o   = r_ready_i & ~to_clint;
	assign clint_ar_addr_o  = ar_addr_i;
	assign clint_ar_valid_o = ar_valid_i & to_clint;
	assign clint_r_ready_o  = r_ready_i & to_clint;

	// response side
	assign ar_ready_o = to_clint ? clint_ar_ready_i : sram_ar_ready_i;
	assign r_data_o   = to_clint ? clint_r_data_i : sram_r_data_i;
	assign r_resp_o   = to_clint ? clint_r_resp_i : sram_r_resp_i;
	assign r_valid_o  = to_clint ? clint_r_valid_i : sram_r_valid_i;
	assign r_last_o   = to_clint ? clint_r_last_i : sram_r_last_i;
	assign r_id_o     = to_clint ? '0 : sram_r_id_i;	// timer carries no id

	// CLINT is read only, so writes always land in SRAM
	assign sram_aw_addr_o  = aw_addr_i;
	assign sram_aw_valid_o = aw_valid_i;
	assign aw_ready_o      = sram_aw_ready_i;
	assign sram_aw_id_o    = aw_id_i;
	assign sram_aw_burst_o = aw_burst_i;
	assign sram_w_data_o   = w_data_i;
	assign sram_w_strb_o   = w_strb_i;
	assign sram_w_valid_o  = w_valid_i;
	assign w_ready_o       = sram_w_ready_i;
	assign sram_w_last_o   = w_last_i;
	assign b_resp_o        = sram_b_resp_i;
	assign b_valid_o       = sram_b_valid_i;
	assign sram_b_ready_o  = b_ready_i;
	assign b_id_o          = sram_b_id_i;

endmodule

`default_nettype wire

//--- source/clint_timer.sv
/*
 * CLINT timer, free running 64-bit mtime readable one word per beat
 */
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_consts.svh"

module clint_timer (
	input  logic                 clock,
	input  logic                 rst_n_i,
	input  logic [`ADDR_LEN-1:0] ar_addr_i,
	input  logic                 ar_valid_i,
	output logic                 ar_ready_o,
	output logic [`DATA_LEN-1:0] r_data_o,
	output logic [`RESP_LEN-1:0] r_resp_o,
	output logic                 r_valid_o,
	output logic                 r_last_o,
	input  logic                 r_ready_i
);

	logic [63:0]          mtime;
	logic                 pending;	// response waiting for r_ready
	logic [`DATA_LEN-1:0] rdata;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mtime <= 64'd0;
		end else begin
			mtime <= mtime + 64'd1;
		end
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pending <= 1'b0;
		end else if (ar_valid_i && ar_ready_o) begin
			pending <= 1'b1;
		end else if (r_valid_o && r_ready_i) begin
			pending <= 1'b0;
		end
	end

	// sample at the handshake, bit 2 picks the upper word
	always_ff @(posedge clock) begin
		if (ar_valid_i && ar_ready_o) begin
			rdata <= ar_addr_i[2] ? mtime[63:32] : mtime[31:0];
		end
	end

	assign ar_ready_o = ~pending;
	assign r_valid_o  = pending;
	assign r_data_o   = rdata;
	assign r_resp_o   = `RESP_OKAY;
	assign r_last_o   = pending;	// single beat, last on every response

endmodule

`default_nettype wire

//--- source/sram_slave.sv
/*
 * On-chip SRAM slave with INCR/FIXED bursts and byte strobes,
 * one transaction at a time, reads take priority over writes
 */
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_consts.svh"

module sram_slave (
	input  logic                  clock,
	input  logic                  rst_n_i,
	input  logic [`ADDR_LEN-1:0]  ar_addr_i,
	input  logic                  ar_valid_i,
	output logic                  ar_ready_o,
	input  logic [`ID_LEN-1:0]    ar_id_i,
	input  logic [`AXLEN_LEN-1:0] ar_len_i,
	input  logic [1:0]            ar_burst_i,
	output logic [`DATA_LEN-1:0]  r_data_o,
	output logic [`RESP_LEN-1:0]  r_resp_o,
	output logic                  r_valid_o,
	input  logic                  r_ready_i,
	output logic                  r_last_o,
	output logic [`ID_LEN-1:0]    r_id_o,
	input  logic [`ADDR_LEN-1:0]  aw_addr_i,
	input  logic                  aw_valid_i,
	output logic                  aw_ready_o,
	input  logic [`ID_LEN-1:0]    aw_id_i,
	input  logic [1:0]            aw_burst_i,
	input  logic [`DATA_LEN-1:0]  w_data_i,
	input  logic [`STRB_LEN-1:0]  w_strb_i,
	input  logic                  w_valid_i,
	output logic                  w_ready_o,
	input  logic                  w_last_i,
	output logic [`RESP_LEN-1:0]  b_resp_o,
	output logic                  b_valid_o,
	input  logic                  b_ready_i,
	output logic [`ID_LEN-1:0]    b_id_o
);

	soc_bus_pkg::sram_state_e state;
	soc_bus_pkg::burst_e      burst_q;
	logic [`AXLEN_LEN-1:0]    beat_cnt;
	logic [`AXLEN_LEN-1:0]    len_q;
	logic [`SRAM_IDX_LEN-1:0] idx;	// current word, wraps at the top
	logic [`ID_LEN-1:0]       id_q;
	logic [`DATA_LEN-1:0]     mem [0:`SRAM_DEPTH_WORDS-1];
	logic                     ar_hs, aw_hs, r_hs, w_hs, b_hs;

	assign ar_ready_o = (state == soc_bus_pkg::SRAM_IDLE);
	assign aw_ready_o = (state == soc_bus_pkg::SRAM_IDLE) && !ar_valid_i;	// read wins
	assign r_valid_o  = (state == soc_bus_pkg::SRAM_READ);
	assign w_ready_o  = (state == soc_bus_pkg::SRAM_WRITE);
	assign b_valid_o  = (state == soc_bus_pkg::SRAM_RESP);

	assign ar_hs = ar_valid_i && ar_ready_o;
	assign aw_hs = aw_valid_i && aw_ready_o;
	assign r_hs  = r_valid_o && r_ready_i;
	assign w_hs  = w_valid_i && w_ready_o;
	assign b_hs  = b_valid_o && b_ready_i;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state    <= soc_bus_pkg::SRAM_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				soc_bus_pkg::SRAM_IDLE: begin
					if (ar_hs) begin
						state    <= soc_bus_pkg::SRAM_READ;
						beat_cnt <= '0;
					end else if (aw_hs) begin
						state <= soc_bus_pkg::SRAM_WRITE;
					end
				end
				soc_bus_pkg::SRAM_READ: begin
					if (r_hs) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (r_last_o) state <= soc_bus_pkg::SRAM_IDLE;
					end
				end
				soc_bus_pkg::SRAM_WRITE: begin
					if (w_hs && w_last_i) state <= soc_bus_pkg::SRAM_RESP;
				end
				soc_bus_pkg::SRAM_RESP: begin
					if (b_hs) state <= soc_bus_pkg::SRAM_IDLE;
				end
				default: state <= soc_bus_pkg::SRAM_IDLE;
			endcase
		end
	end

	// address, length and id of the running burst
	always_ff @(posedge clock) begin
		if (ar_hs) begin
			idx     <= ar_addr_i[`SRAM_IDX_LEN+1:2];
			len_q   <= ar_len_i;
			burst_q <= soc_bus_pkg::burst_e'(ar_burst_i);
			id_q    <= ar_id_i;
		end else if (aw_hs) begin
			idx     <= aw_addr_i[`SRAM_IDX_LEN+1:2];
			burst_q <= soc_bus_pkg::burst_e'(aw_burst_i);
			id_q    <= aw_id_i;
		end else if ((r_hs || w_hs) && burst_q == soc_bus_pkg::BURST_INCR) begin
			idx <= idx + 1'b1;	// FIXED keeps the word
		end
	end

	always_ff @(posedge clock) begin
		if (w_hs) begin
			for (int b = 0; b < `STRB_LEN; b++) begin
				if (w_strb_i[b]) mem[idx][b*8 +: 8] <= w_data_i[b*8 +: 8];
			end
		end
	end

	assign r_data_o = mem[idx];
	assign r_last_o = r_valid_o && (beat_cnt == len_q);
	assign r_resp_o = `RESP_OKAY;
	assign r_id_o   = id_q;
	assign b_resp_o = `RESP_OKAY;
	assign b_id_o   = id_q;

endmodule

`default_nettype wire

//--- source/soc_bus.sv
/*
 * SoC memory bus top, one master reaching SRAM and CLINT through the crossbar
 */
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_consts.svh"

module soc_bus (
	input  logic                  clock,
	input  logic                  rst_n_i,
	input  logic [`ADDR_LEN-1:0]  ar_addr_i,
	input  logic                  ar_valid_i,
	output logic                  ar_ready_o,
	input  logic [`ID_LEN-1:0]    ar_id_i,
	input  logic [`AXLEN_LEN-1:0] ar_len_i,
	input  logic [1:0]            ar_burst_i,
	output logic [`DATA_LEN-1:0]  r_data_o,
	output logic [`RESP_LEN-1:0]  r_resp_o,
	output logic                  r_valid_o,
	input  logic                  r_ready_i,
	output logic                  r_last_o,
	output logic [`ID_LEN-1:0]    r_id_o,
	input  logic [`ADDR_LEN-1:0]  aw_addr_i,
	input  logic                  aw_valid_i,
	output logic                  aw_ready_o,
	input  logic [`ID_LEN-1:0]    aw_id_i,
	input  logic [1:0]            aw_burst_i,
	input  logic [`DATA_LEN-1:0]  w_data_i,
	input  logic [`STRB_LEN-1:0]  w_strb_i,
	input  logic                  w_valid_i,
	output logic                  w_ready_o,
	input  logic                  w_last_i,
	output logic [`RESP_LEN-1:0]  b_resp_o,
	output logic                  b_valid_o,
	input  logic                  b_ready_i,
	output logic [`ID_LEN-1:0]    b_id_o
);

	soc_bus_pkg::device_e  rd_sel;
	logic [`ADDR_LEN-1:0]  sram_ar_addr, sram_aw_addr, clint_ar_addr;
	logic [`ID_LEN-1:0]    sram_ar_id, sram_r_id, sram_aw_id, sram_b_id;
	logic [`AXLEN_LEN-1:0] sram_ar_len;
	logic [1:0]            sram_ar_burst, sram_aw_burst;
	logic [`DATA_LEN-1:0]  sram_r_data, sram_w_data, clint_r_data;
	logic [`RESP_LEN-1:0]  sram_r_resp, sram_b_resp, clint_r_resp;
	logic [`STRB_LEN-1:0]  sram_w_strb;
	logic                  sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
	logic                  sram_r_last, sram_aw_valid, sram_aw_ready;
	logic                  sram_w_valid, sram_w_ready, sram_w_last;
	logic                  sram_b_valid, sram_b_ready;
	logic                  clint_ar_valid, clint_ar_ready, clint_r_valid;
	logic                  clint_r_last, clint_r_ready;

	device_select i_device_select (
		.clock(clock), .rst_n_i(rst_n_i),
		.ar_addr_i(ar_addr_i), .ar_valid_i(ar_valid_i), .ar_ready_i(ar_ready_o),
		.r_valid_i(r_valid_o), .r_ready_i(r_ready_i), .r_last_i(r_last_o),
		.rd_sel_o(rd_sel)
	);

	bus_xbar i_bus_xbar (
		.ar_addr_i(ar_addr_i), .ar_valid_i(ar_valid_i), .ar_ready_o(ar_ready_o),
		.ar_id_i(ar_id_i), .ar_len_i(ar_len_i), .ar_burst_i(ar_burst_i),
		.r_data_o(r_data_o), .r_resp_o(r_resp_o), .r_valid_o(r_valid_o),
		.r_ready_i(r_ready_i), .r_last_o(r_last_o), .r_id_o(r_id_o),
		.aw_addr_i(aw_addr_i), .aw_valid_i(aw_valid_i), .aw_ready_o(aw_ready_o),
		.aw_id_i(aw_id_i), .aw_burst_i(aw_burst_i),
		.w_data_i(w_data_i), .w_strb_i(w_strb_i), .w_valid_i(w_valid_i),
		.w_ready_o(w_ready_o), .w_last_i(w_last_i),
		.b_resp_o(b_resp_o), .b_valid_o(b_valid_o), .b_ready_i(b_ready_i), .b_id_o(b_id_o),
		.rd_sel_i(rd_sel),
		.sram_ar_addr_o(sram_ar_addr), .sram_ar_valid_o(sram_ar_valid),
		.sram_ar_ready_i(sram_ar_ready), .sram_ar_id_o(sram_ar_id),
		.sram_ar_len_o(sram_ar_len), .sram_ar_burst_o(sram_ar_burst),
		.sram_r_data_i(sram_r_data), .sram_r_resp_i(sram_r_resp),
		.sram_r_valid_i(sram_r_valid), .sram_r_ready_o(sram_r_ready),
		.sram_r_last_i(sram_r_last), .sram_r_id_i(sram_r_id),
		.sram_aw_addr_o(sram_aw_addr), .sram_aw_valid_o(sram_aw_valid),
		.sram_aw_ready_i(sram_aw_ready), .sram_aw_id_o(sram_aw_id),
		.sram_aw_burst_o(sram_aw_burst),
		.sram_w_data_o(sram_w_data), .sram_w_strb_o(sram_w_strb),
		.sram_w_valid_o(sram_w_valid), .sram_w_ready_i(sram_w_ready),
		.sram_w_last_o(sram_w_last),
		.sram_b_resp_i(sram_b_resp), .sram_b_valid_i(sram_b_valid),
		.sram_b_ready_o(sram_b_ready), .sram_b_id_i(sram_b_id),
		.clint_ar_addr_o(clint_ar_addr), .clint_ar_valid_o(clint_ar_valid),
		.clint_ar_ready_i(clint_ar_ready), .clint_r_data_i(clint_r_data),
		.clint_r_resp_i(clint_r_resp), .clint_r_valid_i(clint_r_valid),
		.clint_r_last_i(clint_r_last), .clint_r_ready_o(clint_r_ready)
	);

	clint_timer i_clint_timer (
		.clock(clock), .rst_n_i(rst_n_i),
		.ar_addr_i(clint_ar_addr), .ar_valid_i(clint_ar_valid), .ar_ready_o(clint_ar_ready),
		.r_data_o(clint_r_data), .r_resp_o(clint_r_resp), .r_valid_o(clint_r_valid),
		.r_last_o(clint_r_last), .r_ready_i(clint_r_ready)
	);

	sram_slave i_sram_slave (
		.clock(clock), .rst_n_i(rst_n_i),
		.ar_addr_i(sram_ar_addr), .ar_valid_i(sram_ar_valid), .ar_ready_o(sram_ar_ready),
		.ar_id_i(sram_ar_id), .ar_len_i(sram_ar_len), .ar_burst_i(sram_ar_burst),
		.r_data_o(sram_r_data), .r_resp_o(sram_r_resp), .r_valid_o(sram_r_valid),
		.r_ready_i(sram_r_ready), .r_last_o(sram_r_last), .r_id_o(sram_r_id),
		.aw_addr_i(sram_aw_addr), .aw_valid_i(sram_aw_valid), .aw_ready_o(sram_aw_ready),
		.aw_id_i(sram_aw_id), .aw_burst_i(sram_aw_burst),
		.w_data_i(sram_w_data), .w_strb_i(sram_w_strb), .w_valid_i(sram_w_valid),
		.w_ready_o(sram_w_ready), .w_last_i(sram_w_last),
		.b_resp_o(sram_b_resp), .b_valid_o(sram_b_valid), .b_ready_i(sram_b_ready),
		.b_id_o(sram_b_id)
	);

endmodule

`default_nettype wire

//--- verif/soc_bus_props.sv
/*
 * Bus protocol checks on the master side of the SoC memory bus
 */
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_consts.svh"

module soc_bus_props (
	input logic                 clock,
	input logic                 rst_n_i,
	input logic                 r_valid_i,
	input logic                 r_ready_i,
	input logic [`DATA_LEN-1:0] r_data_i,
	input logic                 r_last_i,
	input logic [`ID_LEN-1:0]   r_id_i,
	input logic [`RESP_LEN-1:0] r_resp_i,
	input logic                 b_valid_i,
	input logic                 b_ready_i,
	input logic [`RESP_LEN-1:0] b_resp_i,
	input logic [`ID_LEN-1:0]   b_id_i,
	input logic                 aw_valid_i,
	input logic [`ADDR_LEN-1:0] aw_addr_i
);

	r_held: assert property (@(posedge clock) disable iff (!rst_n_i)
		r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_last_i)
			&& $stable(r_id_i) && $stable(r_resp_i))
		else $error("r payload changed before its handshake");

	b_held: assert property (@(posedge clock) disable iff (!rst_n_i)
		b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_resp_i) && $stable(b_id_i))
		else $error("b payload changed before its handshake");

	aw_not_clint: assert property (@(posedge clock) disable iff (!rst_n_i)
		aw_valid_i |-> ((aw_addr_i & `CLINT_MASK) != `CLINT_BASE))
		else $error("write address falls in the CLINT region");

	last_in_beat: assert property (@(posedge clock) disable iff (!rst_n_i)
		r_last_i |-> r_valid_i)
		else $error("r_last raised outside a valid beat");

endmodule

`default_nettype wire

//--- verif/soc_bus_tb.sv
/*
 * Testbench for the SoC memory bus, random bursts to SRAM and CLINT reads
 * checked against a byte-strobed word model
 */
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_consts.svh"

module soc_bus_tb;

	localparam int CLK_PERIOD     = 40;
	localparam int NUM_TXN        = 200;	// bound on bus transactions in the run
	localparam int MAX_TXN_CYCLES = 100;	// 8 beats under random ready, with margin
	localparam int RAND_ITERS     = 40;

	logic                  clock, rst_n_i;
	logic [`ADDR_LEN-1:0]  ar_addr_i, aw_addr_i;
	logic                  ar_valid_i, ar_ready_o, r_valid_o, r_ready_i, r_last_o;
	logic [`ID_LEN-1:0]    ar_id_i, r_id_o, aw_id_i, b_id_o;
	logic [`AXLEN_LEN-1:0] ar_len_i;
	logic [1:0]            ar_burst_i, aw_burst_i;
	logic [`DATA_LEN-1:0]  r_data_o, w_data_i;
	logic [`RESP_LEN-1:0]  r_resp_o, b_resp_o;
	logic                  aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i;
	logic [`STRB_LEN-1:0]  w_strb_i;
	logic                  b_valid_o, b_ready_i;

	logic [`DATA_LEN-1:0] model [0:`SRAM_DEPTH_WORDS-1];
	logic [31:0]          cycle_cnt;	// clocks since reset release
	integer               seed;
	int                   errors, tests_ok, tests_bad;

	soc_bus i_soc_bus (.*);

	bind soc_bus soc_bus_props i_soc_bus_props (
		.clock(clock), .rst_n_i(rst_n_i),
		.r_valid_i(r_valid_o), .r_ready_i(r_ready_i), .r_data_i(r_data_o),
		.r_last_i(r_last_o), .r_id_i(r_id_o), .r_resp_i(r_resp_o),
		.b_valid_i(b_valid_o), .b_ready_i(b_ready_i), .b_resp_i(b_resp_o), .b_id_i(b_id_o),
		.aw_valid_i(aw_valid_i), .aw_addr_i(aw_addr_i)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	always @(posedge clock) begin
		if (rst_n_i) cycle_cnt <= cycle_cnt + 32'd1;
	end

	task automatic check(input bit ok, input string msg);
		assert (ok) else begin
			$display("ERR %0t ns: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		if (errors == err_start) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: FAILED with %0d errors", name, errors - err_start);
		end
	endtask

	// fill word built from the full word index
	function automatic logic [31:0] fill_word(input logic [7:0] idx);
		return {idx, ~idx, idx ^ 8'h5A, idx + 8'hC3};
	endfunction

	task automatic send_ar(input [31:0] addr, input [3:0] id, input [7:0] len,
		input [1:0] burst);
		ar_addr_i  = addr;
		ar_id_i    = id;
		ar_len_i   = len;
		ar_burst_i = burst;
		ar_valid_i = 1'b1;
		#1;
		while (!ar_ready_o) begin
			@(negedge clock);
			#1;
		end
		@(negedge clock);
		ar_valid_i = 1'b0;
	endtask

	task automatic write_burst(input [31:0] addr, input [7:0] len, input [1:0] burst,
		input [3:0] id, input bit fill);
		logic [7:0]  idx;
		logic [31:0] data;
		logic [3:0]  strb;
		int          beat;
		bit          hs;
		idx        = addr[9:2];
		beat       = 0;
		aw_addr_i  = addr;
		aw_id_i    = id;
		aw_burst_i = burst;
		aw_valid_i = 1'b1;
		#1;
		while (!aw_ready_o) begin
			@(negedge clock);
			#1;
		end
		@(negedge clock);
		aw_valid_i = 1'b0;
		while (beat <= int'(len)) begin
			data      = fill ? fill_word(idx) : 32'($random(seed));
			strb      = fill ? 4'hF : 4'($random(seed));
			w_data_i  = data;
			w_strb_i  = strb;
			w_last_i  = (beat == int'(len));
			w_valid_i = 1'b1;
			#1;
			while (!w_ready_o) begin
				@(negedge clock);
				#1;
			end
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) model[idx][b*8 +: 8] = data[b*8 +: 8];
			end
			if (burst == soc_bus_pkg::BURST_INCR) idx++;
			beat++;
			@(negedge clock);
		end
		w_valid_i = 1'b0;
		w_last_i  = 1'b0;
		do begin
			b_ready_i = 1'($random(seed));
			#1;
			hs = b_valid_o && b_ready_i;
			if (hs) begin
				check(b_resp_o == `RESP_OKAY, "write response not OKAY");
				check(b_id_o == id, $sformatf("b_id %0h, expected %0h", b_id_o, id));
			end
			@(negedge clock);
		end while (!hs);
		b_ready_i = 1'b0;
	endtask

	task automatic read_burst(input [31:0] addr, input [7:0] len, input [1:0] burst,
		input [3:0] id);
		logic [7:0] idx;
		int         beat;
		idx  = addr[9:2];
		beat = 0;
		send_ar(addr, id, len, burst);
		ar_addr_i = `CLINT_BASE | {16'h0, `MTIME_LO_ADDR};	// decode now points at the timer
		while (beat <= int'(len)) begin
			r_ready_i = 1'($random(seed));
			#1;
			check(i_soc_bus.rd_sel == soc_bus_pkg::DEV_SRAM, "read route left SRAM early");
			if (r_valid_o && r_ready_i) begin
				check(r_data_o == model[idx], $sformatf("word %0d read %h, expected %h",
					idx, r_data_o, model[idx]));
				check(r_last_o == (beat == int'(len)), $sformatf("r_last wrong on beat %0d",
					beat));
				check(r_id_o == id && r_resp_o == `RESP_OKAY, "r_id or r_resp wrong");
				if (burst == soc_bus_pkg::BURST_INCR) idx++;
				beat++;
			end
			@(negedge clock);
		end
		r_ready_i = 1'b0;
		check(i_soc_bus.rd_sel == soc_bus_pkg::DEV_CLINT, "route still held after last beat");
	endtask

	task automatic clint_read(input bit hi, output logic [31:0] val);
		bit hs;
		send_ar(`CLINT_BASE | {16'h0, hi ? `MTIME_HI_ADDR : `MTIME_LO_ADDR},
			4'($random(seed)), 8'd0, soc_bus_pkg::BURST_INCR);
		ar_addr_i = '0;	// decode now points at the SRAM
		do begin
			r_ready_i = 1'($random(seed));
			#1;
			check(i_soc_bus.rd_sel == soc_bus_pkg::DEV_CLINT, "timer read not routed to CLINT");
			hs = r_valid_o && r_ready_i;
			if (hs) begin
				check(r_resp_o == `RESP_OKAY && r_last_o, "timer resp or last wrong");
				check(r_id_o == '0, $sformatf("timer r_id %0h, expected 0", r_id_o));
				val = r_data_o;
			end
			@(negedge clock);
		end while (!hs);
		r_ready_i = 1'b0;
		check(i_soc_bus.rd_sel == soc_bus_pkg::DEV_SRAM, "timer route held after its beat");
	endtask

	initial begin
		logic [31:0] addr, val, prev;
		logic [7:0]  len;
		logic [1:0]  burst;
		int          err_start;
		seed = 50;
		errors = 0;
		tests_ok = 0;
		tests_bad = 0;
		cycle_cnt = '0;
		clock = 1'b0;
		rst_n_i = 1'b0;
		ar_addr_i = '0;
		ar_valid_i = 1'b0;
		ar_id_i = '0;
		ar_len_i = '0;
		ar_burst_i = 2'b01;
		r_ready_i = 1'b0;
		aw_addr_i = '0;
		aw_valid_i = 1'b0;
		aw_id_i = '0;
		aw_burst_i = 2'b01;
		w_data_i = '0;
		w_strb_i = '0;
		w_valid_i = 1'b0;
		w_last_i = 1'b0;
		b_ready_i = 1'b0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		rst_n_i = 1'b1;

		err_start = errors;
		#1;
		check(!r_valid_o && !b_valid_o && ar_ready_o && aw_ready_o, "idle outputs after reset");
		clint_read(1'b0, val);
		check(val < 32'd64, $sformatf("mtime %0d not near zero after reset", val));
		end_test("reset", err_start);

		err_start = errors;
		for (int i = 0; i < 32; i++) begin
			write_burst(32'(i) * 32'd32, 8'd7, soc_bus_pkg::BURST_INCR, 4'(i), 1'b1);
		end
		for (int i = 0; i < 32; i++) begin
			read_burst(32'(i) * 32'd32, 8'd7, soc_bus_pkg::BURST_INCR, 4'(i));
		end
		end_test("sram fill", err_start);

		err_start = errors;
		for (int i = 0; i < RAND_ITERS; i++) begin
			addr  = 32'($random(seed)) & 32'h00FF_FFFC;	// upper bits alias, index wraps
			len   = 8'($random(seed)) & 8'h07;
			burst = (1'($random(seed))) ? soc_bus_pkg::BURST_INCR : soc_bus_pkg::BURST_FIXED;
			write_burst(addr, len, burst, 4'($random(seed)), 1'b0);
			read_burst(addr, len, burst, 4'($random(seed)));
		end
		end_test("random bursts", err_start);

		err_start = errors;
		clint_read(1'b0, prev);
		for (int i = 0; i < 7; i++) begin
			clint_read(1'b0, val);
			check(val > prev, $sformatf("mtime low %0d not above %0d", val, prev));
			prev = val;
		end
		clint_read(1'b1, prev);
		// run is far shorter than 2^32 clocks
		check(prev == 32'd0, $sformatf("mtime high word %0d, expected 0", prev));
		for (int i = 0; i < 3; i++) begin
			clint_read(1'b1, val);
			check(val >= prev, "mtime high word went down");
			prev = val;
		end
		end_test("clint reads", err_start);

		err_start = errors;
		for (int i = 0; i < 10; i++) begin
			addr = 32'($random(seed)) & 32'h0000_03FC;
			len  = 8'($random(seed)) & 8'h07;
			read_burst(addr, len, soc_bus_pkg::BURST_INCR, 4'($random(seed)));
			clint_read(1'b0, val);
			check(val <= cycle_cnt, $sformatf("timer value %0d beyond elapsed cycles", val));
		end
		end_test("alternating routes", err_start);

		$display("tests passed %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
		if (errors == 0 && tests_bad == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// run limit scales with the transaction count
	initial begin
		#(NUM_TXN * MAX_TXN_CYCLES * CLK_PERIOD);
		$display("timeout: bus transactions did not complete in the allowed time");
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- soc_bus.f
+incdir+source
source/soc_bus_pkg.sv
source/device_select.sv
source/bus_xbar.sv
source/clint_timer.sv
source/sram_slave.sv
source/soc_bus.sv
verif/soc_bus_props.sv
verif/soc_bus_tb.sv

//--- Makefile
# Verilator build and run for the SoC memory bus testbench

VERILATOR ?= verilator
TOP       ?= soc_bus_tb
RTL_TOP   ?= soc_bus
FILELIST  ?= soc_bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "Testbench passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
